/* rtl/ti_pkg.sv */
package ti_pkg;

    localparam int FLIT_W = 32;

    typedef logic [FLIT_W-1:0] flit_t;      // NoC flit or source word

    // Every packet starts with the same fixed header
    localparam int HEADER_SIZE = 13;

    typedef logic [3:0] hdr_idx_t;          // Counts 0 to HEADER_SIZE
    typedef logic [7:0] task_idx_t;
    typedef logic [7:0] app_id_t;

    // Service codes in header flit 2
    localparam flit_t MESSAGE_DELIVERY = 32'h0000_0001;
    localparam flit_t TASK_ALLOCATION  = 32'h0000_0040;

    // Delivery codes in payload word 0
    localparam flit_t APP_ALLOCATION_REQUEST = 32'h0000_0240;
    localparam flit_t APP_MAPPING_COMPLETE   = 32'h0000_0241;

    // Text, data, bss, entry point
    localparam int SIZE_WORDS = 4;

endpackage

/* rtl/noc_receiver.sv */
module noc_receiver #(
    parameter int MAX_PAYLOAD = 32
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              noc_rx_i,
    input  ti_pkg::flit_t     noc_data_i,
    input  ti_pkg::task_idx_t target_sel_i,
    output logic              noc_credit_o,
    output logic              alloc_o,
    output logic              complete_o,
    output ti_pkg::app_id_t   app_id_o,
    output ti_pkg::flit_t     target_addr_o
);

    localparam int IDX_W = $clog2(MAX_PAYLOAD);

    ti_pkg::hdr_idx_t hdr_cnt_q;
    ti_pkg::flit_t    pay_cnt_q;
    ti_pkg::flit_t    len_q, svc_q, code_q;
    ti_pkg::flit_t    tbl_q [MAX_PAYLOAD];    // Payload words of the last allocation
    logic             dec_q, alloc_q, cmpl_q;

    ti_pkg::flit_t pay_len, word0;
    logic          xfer, in_pay, is_dlv, last_hdr, last_pay, pkt_end, pay_wr;

    assign xfer    = noc_rx_i && noc_credit_o;
    assign in_pay  = hdr_cnt_q == ti_pkg::hdr_idx_t'(ti_pkg::HEADER_SIZE);
    assign is_dlv  = svc_q == ti_pkg::MESSAGE_DELIVERY;
    assign pay_len = len_q - ti_pkg::flit_t'(ti_pkg::HEADER_SIZE - 2);

    // Header-only packet ends on flit 12
    assign last_hdr = hdr_cnt_q == ti_pkg::hdr_idx_t'(ti_pkg::HEADER_SIZE - 1)
                      && len_q == ti_pkg::flit_t'(ti_pkg::HEADER_SIZE - 2);
    assign last_pay = in_pay && pay_cnt_q == pay_len - 1'b1;
    assign pkt_end  = xfer && (last_hdr || last_pay);

    // Single-word payload ends on word 0 itself
    assign word0 = (in_pay && pay_cnt_q == '0) ? noc_data_i : code_q;

    assign pay_wr = xfer && in_pay && pay_cnt_q != '0
                    && pay_cnt_q < ti_pkg::flit_t'(MAX_PAYLOAD)
                    && is_dlv && code_q == ti_pkg::APP_ALLOCATION_REQUEST;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hdr_cnt_q <= '0;
            pay_cnt_q <= '0;
            dec_q     <= 1'b0;
            alloc_q   <= 1'b0;
            cmpl_q    <= 1'b0;
        end else begin
            dec_q   <= pkt_end;
            alloc_q <= pkt_end && !last_hdr && is_dlv && word0 == ti_pkg::APP_ALLOCATION_REQUEST;
            cmpl_q  <= pkt_end && !last_hdr && is_dlv && word0 == ti_pkg::APP_MAPPING_COMPLETE;
            if (pkt_end) begin
                hdr_cnt_q <= '0;
                pay_cnt_q <= '0;
            end else if (xfer) begin
                if (!in_pay)
                    hdr_cnt_q <= hdr_cnt_q + 1'b1;
                else
                    pay_cnt_q <= pay_cnt_q + 1'b1;   // Runs past MAX_PAYLOAD unstored
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer && hdr_cnt_q == 4'd1)
            len_q <= noc_data_i;
        if (xfer && hdr_cnt_q == 4'd2)
            svc_q <= noc_data_i;
        if (xfer && in_pay && pay_cnt_q == '0)
            code_q <= noc_data_i;
        if (pay_wr)
            tbl_q[pay_cnt_q[IDX_W-1:0]] <= noc_data_i;
    end

    assign noc_credit_o = !dec_q;     // Low in the decode cycle
    assign alloc_o      = alloc_q;
    assign complete_o   = cmpl_q;
    assign app_id_o     = tbl_q[1][7:0];

    always_comb begin
        if (int'(target_sel_i) < MAX_PAYLOAD)
            target_addr_o = tbl_q[target_sel_i[IDX_W-1:0]];
        else
            target_addr_o = '0;
    end

    // Word 0 must have arrived in an earlier cycle of the payload phase
    a_pay_after_hdr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pay_wr |-> $past(hdr_cnt_q) == ti_pkg::hdr_idx_t'(ti_pkg::HEADER_SIZE));

endmodule

/* rtl/task_header_builder.sv */
module task_header_builder #(
    parameter ti_pkg::flit_t MAPPER_ADDRESS = '0
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              start_task_i,
    input  ti_pkg::task_idx_t task_i,
    input  ti_pkg::app_id_t   app_id_i,
    input  ti_pkg::flit_t     target_addr_i,
    input  logic              src_rx_i,
    input  ti_pkg::flit_t     src_data_i,
    input  logic              src_credit_i,
    input  ti_pkg::hdr_idx_t  hdr_idx_i,
    output ti_pkg::task_idx_t target_sel_o,
    output logic              sizes_done_o,
    output ti_pkg::flit_t     code_len_o,
    output ti_pkg::flit_t     hdr_flit_o
);

    ti_pkg::flit_t sizes_q [ti_pkg::SIZE_WORDS];   // Text, data, bss, entry
    logic [2:0]    cnt_q;
    logic          take;

    assign sizes_done_o = cnt_q == 3'(ti_pkg::SIZE_WORDS);
    assign take         = src_rx_i && src_credit_i && !sizes_done_o;

    // Full after reset so that the task count is not taken as a size
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni)
            cnt_q <= 3'(ti_pkg::SIZE_WORDS);
        else if (start_task_i)
            cnt_q <= '0;
        else if (take)
            cnt_q <= cnt_q + 1'b1;
    end

    always_ff @(posedge clk_i) begin
        if (take)
            sizes_q[cnt_q[1:0]] <= src_data_i;
    end

    assign code_len_o   = (sizes_q[0] + sizes_q[1]) >> 2;   // Bytes to words
    assign target_sel_o = task_i + 8'd2;                    // Payload words 2 and up

    always_comb begin
        case (hdr_idx_i)
            4'd0:    hdr_flit_o = target_addr_i;
            4'd1:    hdr_flit_o = code_len_o + ti_pkg::flit_t'(ti_pkg::HEADER_SIZE - 2);
            4'd2:    hdr_flit_o = ti_pkg::TASK_ALLOCATION;
            4'd3:    hdr_flit_o = {{(ti_pkg::FLIT_W - 16){1'b0}}, app_id_i, task_i};
            4'd4:    hdr_flit_o = MAPPER_ADDRESS;
            4'd9:    hdr_flit_o = sizes_q[1];
            4'd10:   hdr_flit_o = sizes_q[0];
            4'd11:   hdr_flit_o = sizes_q[2];
            4'd12:   hdr_flit_o = sizes_q[3];
            default: hdr_flit_o = '0;
        endcase
    end

endmodule

/* rtl/packet_sender.sv */
module packet_sender (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             send_start_i,
    input  logic             size_accept_i,
    input  ti_pkg::flit_t    hdr_flit_i,
    input  ti_pkg::flit_t    code_len_i,
    input  logic             noc_credit_i,
    input  logic             src_rx_i,
    input  ti_pkg::flit_t    src_data_i,
    output ti_pkg::hdr_idx_t hdr_idx_o,
    output logic             noc_tx_o,
    output ti_pkg::flit_t    noc_data_o,
    output logic             src_credit_o,
    output logic             send_done_o
);

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        CODE
    } state_t;

    state_t           state_q;
    ti_pkg::hdr_idx_t idx_q;
    ti_pkg::flit_t    code_cnt_q;
    logic             done_q;
    logic             hdr_last, code_xfer;

    assign hdr_last  = idx_q == ti_pkg::hdr_idx_t'(ti_pkg::HEADER_SIZE - 1);
    assign code_xfer = state_q == CODE && src_rx_i && noc_credit_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            idx_q      <= '0;
            code_cnt_q <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE: if (send_start_i) begin
                    state_q <= HEADER;
                    idx_q   <= '0;
                end
                HEADER: if (noc_credit_i) begin
                    if (!hdr_last) begin
                        idx_q <= idx_q + 1'b1;
                    end else if (code_len_i == '0) begin
                        state_q <= IDLE;     // No code words to forward
                        done_q  <= 1'b1;
                    end else begin
                        state_q    <= CODE;
                        code_cnt_q <= '0;
                    end
                end
                CODE: if (code_xfer) begin
                    code_cnt_q <= code_cnt_q + 1'b1;
                    if (code_cnt_q == code_len_i - 1'b1) begin
                        state_q <= IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign hdr_idx_o    = idx_q;
    assign send_done_o  = done_q;
    assign noc_tx_o     = state_q == HEADER || (state_q == CODE && src_rx_i);
    assign noc_data_o   = (state_q == CODE) ? src_data_i : hdr_flit_i;
    assign src_credit_o = (state_q == CODE) ? noc_credit_i : size_accept_i;

    a_hold_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
        noc_tx_o && !noc_credit_i |=> $stable(noc_data_o));

endmodule

/* rtl/injector_ctrl.sv */
module injector_ctrl (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              src_rx_i,
    input  ti_pkg::flit_t     src_data_i,
    input  logic              alloc_i,
    input  logic              complete_i,
    input  logic              sizes_done_i,
    input  logic              send_done_i,
    output logic              start_task_o,
    output ti_pkg::task_idx_t task_o,
    output logic              send_start_o,
    output logic              size_accept_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_ALLOC,
        LOAD_SIZES,
        SEND_TASK,
        WAIT_COMPLETE
    } state_t;

    state_t            state_q, state_d;
    ti_pkg::task_idx_t count_q, task_q;
    logic              last_task;

    assign last_task = task_q == count_q - 8'd1;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:          if (src_rx_i) state_d = WAIT_ALLOC;      // Task count taken
            WAIT_ALLOC:    if (alloc_i) state_d = LOAD_SIZES;
            LOAD_SIZES:    if (sizes_done_i) state_d = SEND_TASK;
            SEND_TASK: begin
                if (send_done_i)
                    state_d = last_task ? WAIT_COMPLETE : LOAD_SIZES;
            end
            WAIT_COMPLETE: if (complete_i) state_d = IDLE;
            default:       state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            count_q <= '0;
            task_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE && src_rx_i) begin
                count_q <= src_data_i[7:0];
                task_q  <= '0;
            end else if (state_q == SEND_TASK && send_done_i && !last_task) begin
                task_q <= task_q + 1'b1;
            end
        end
    end

    assign start_task_o = (state_q == WAIT_ALLOC && alloc_i)
                          || (state_q == SEND_TASK && send_done_i && !last_task);
    assign send_start_o = state_q == LOAD_SIZES && sizes_done_i;
    // Source held off once the four sizes are in, the next word is code
    assign size_accept_o = state_q == IDLE || (state_q == LOAD_SIZES && !sizes_done_i);
    assign task_o        = task_q;

    a_count_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
        state_q == IDLE && src_rx_i |=> count_q != '0);

endmodule

/* rtl/task_injector.sv */
module task_injector #(
    parameter ti_pkg::flit_t MAPPER_ADDRESS = 32'h0000_0000,
    parameter int            MAX_PAYLOAD    = 32
) (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          src_rx_i,
    input  ti_pkg::flit_t src_data_i,
    output logic          src_credit_o,
    output logic          noc_tx_o,
    output ti_pkg::flit_t noc_data_o,
    input  logic          noc_credit_i,
    input  logic          noc_rx_i,
    input  ti_pkg::flit_t noc_data_i,
    output logic          noc_credit_o
);

    logic              alloc, complete, start_task, sizes_done;
    logic              send_start, size_accept, send_done;
    ti_pkg::task_idx_t task_num, target_sel;
    ti_pkg::app_id_t   app_id;
    ti_pkg::flit_t     target_addr, hdr_flit, code_len;
    ti_pkg::hdr_idx_t  hdr_idx;

    noc_receiver #(
        .MAX_PAYLOAD(MAX_PAYLOAD)
    ) u_receiver (
        .clk_i, .rst_ni, .noc_rx_i, .noc_data_i,
        .target_sel_i (target_sel),
        .noc_credit_o,
        .alloc_o      (alloc),
        .complete_o   (complete),
        .app_id_o     (app_id),
        .target_addr_o(target_addr)
    );

    injector_ctrl u_ctrl (
        .clk_i, .rst_ni, .src_rx_i, .src_data_i,
        .alloc_i      (alloc),
        .complete_i   (complete),
        .sizes_done_i (sizes_done),
        .send_done_i  (send_done),
        .start_task_o (start_task),
        .task_o       (task_num),
        .send_start_o (send_start),
        .size_accept_o(size_accept)
    );

    task_header_builder #(
        .MAPPER_ADDRESS(MAPPER_ADDRESS)
    ) u_builder (
        .clk_i, .rst_ni, .src_rx_i, .src_data_i,
        .start_task_i (start_task),
        .task_i       (task_num),
        .app_id_i     (app_id),
        .target_addr_i(target_addr),
        .src_credit_i (src_credit_o),
        .hdr_idx_i    (hdr_idx),
        .target_sel_o (target_sel),
        .sizes_done_o (sizes_done),
        .code_len_o   (code_len),
        .hdr_flit_o   (hdr_flit)
    );

    packet_sender u_sender (
        .clk_i, .rst_ni, .noc_credit_i, .src_rx_i, .src_data_i,
        .send_start_i (send_start),
        .size_accept_i(size_accept),
        .hdr_flit_i   (hdr_flit),
        .code_len_i   (code_len),
        .hdr_idx_o    (hdr_idx),
        .noc_tx_o, .noc_data_o, .src_credit_o,
        .send_done_o  (send_done)
    );

endmodule

/* tb/tb_task_injector.sv */
module tb_task_injector;

    localparam ti_pkg::flit_t MAPPER = 32'h0000_0101;

    logic          clk_i        = 1'b0;
    logic          rst_ni       = 1'b0;
    logic          src_rx_i     = 1'b0;
    ti_pkg::flit_t src_data_i   = '0;
    logic          noc_credit_i = 1'b1;
    logic          noc_rx_i     = 1'b0;
    ti_pkg::flit_t noc_data_i   = '0;
    logic          src_credit_o, noc_tx_o, noc_credit_o;
    ti_pkg::flit_t noc_data_o;

    ti_pkg::flit_t recs [256];                  // Words of the test file
    ti_pkg::flit_t src_q[$], pkt_q[$], exp_q[$];
    string         name_q[$];                   // Test name of each expected flit
    logic [31:0]   rnd_q   = 32'h80c7;
    logic          gaps_on = 1'b0;
    logic          src_gap = 1'b0;
    int            errors = 0, checks = 0, src_taken = 0, noc_seen = 0, limit_cycles = 0;

    task_injector #(
        .MAPPER_ADDRESS(MAPPER),
        .MAX_PAYLOAD   (32)
    ) dut (.*);

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Text plus data bytes in whole words
    function automatic int code_words(input ti_pkg::flit_t text, input ti_pkg::flit_t data);
        return int'((text + data) >> 2);
    endfunction

    task automatic check_flit(input string name, input ti_pkg::flit_t exp,
                              input ti_pkg::flit_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input ti_pkg::flit_t exp,
                               input ti_pkg::flit_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic expect_flit(input string name, input ti_pkg::flit_t value);
        exp_q.push_back(value);
        name_q.push_back(name);
    endtask

    task automatic send_packet(input ti_pkg::flit_t service, input ti_pkg::flit_t payload[$]);
        pkt_q.push_back(32'h0000_0100);
        pkt_q.push_back(ti_pkg::flit_t'(payload.size() + 11));
        pkt_q.push_back(service);
        repeat (10)
            pkt_q.push_back('0);
        foreach (payload[i])
            pkt_q.push_back(payload[i]);
    endtask

    always @(posedge clk_i) begin
        rnd_q        <= xorshift(rnd_q);
        noc_credit_i <= !gaps_on || rnd_q[1:0] != 2'b00;
        src_gap      <= gaps_on && rnd_q[3:2] == 2'b00;
    end

    // Word source
    always @(posedge clk_i) begin
        if (src_rx_i && src_credit_o) begin
            void'(src_q.pop_front());
            src_taken++;
        end
        if (src_q.size() > 0 && !src_gap) begin
            src_rx_i   <= 1'b1;
            src_data_i <= src_q[0];
        end else begin
            src_rx_i <= 1'b0;
        end
    end

    always @(posedge clk_i) begin
        if (noc_rx_i && noc_credit_o)
            void'(pkt_q.pop_front());
        noc_rx_i <= pkt_q.size() > 0;
        if (pkt_q.size() > 0)
            noc_data_i <= pkt_q[0];
    end

    // NoC output monitor
    always @(posedge clk_i) begin
        if (noc_tx_o && noc_credit_i)
            noc_seen++;
        if (noc_tx_o && exp_q.size() == 0) begin
            errors++;
            $display("noc_tx_o went high at %0t while no task packet was due", $time);
        end else if (noc_tx_o && noc_credit_i) begin
            check_flit(name_q.pop_front(), exp_q.pop_front(), noc_data_o);
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk_i);
        $display("Timeout: the run did not end within %0d cycles", limit_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int              n_apps, p, sz, ntask, clen, limit, taken0, seen0, nwords, nflits;
        ti_pkg::app_id_t app_id;
        ti_pkg::flit_t   pay[$];
        ti_pkg::flit_t   hdr [13];
        string           tag;

        $readmemh("tb/injector_tests.txt", recs);
        n_apps = $isunknown(recs[0]) ? 0 : int'(recs[0]);
        if (n_apps == 0) begin
            errors++;
            $display("The test file tb/injector_tests.txt holds no records");
        end
        limit = 0;
        p     = 1;
        for (int a = 0; a < n_apps; a++) begin
            ntask = int'(recs[p+1]);
            for (int t = 0; t < ntask; t++)
                limit += 200 + 4 * code_words(recs[p+2+ntask+4*t], recs[p+3+ntask+4*t]);
            p += 2 + 5 * ntask;
        end
        limit_cycles = limit;

        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);
        check_level("reset noc_tx_o", 1'b0, noc_tx_o);
        check_level("reset noc_credit_o", 1'b1, noc_credit_o);
        check_level("reset src_credit_o", 1'b1, src_credit_o);

        p = 1;
        for (int a = 0; a < n_apps; a++) begin
            app_id  = recs[p][7:0];
            ntask   = int'(recs[p+1]);
            sz      = p + 2 + ntask;
            gaps_on <= a > 0;                   // First application runs without gaps
            taken0  = src_taken;
            seen0   = noc_seen;
            nwords  = 1;
            nflits  = 0;
            src_q.push_back(ti_pkg::flit_t'(ntask));
            while (src_taken == taken0) @(posedge clk_i);

            // Task words wait in the source ahead of the allocation
            for (int t = 0; t < ntask; t++) begin
                clen = code_words(recs[sz+4*t], recs[sz+4*t+1]);
                for (int i = 0; i < 4; i++)
                    src_q.push_back(recs[sz+4*t+i]);
                for (int i = 0; i < clen; i++)
                    src_q.push_back({app_id, 8'(t), 16'(i)});
                nwords += 4 + clen;
            end

            // Foreign code and then allocation code outside a delivery
            pay.delete();
            pay.push_back(32'h0000_0999);
            pay.push_back(ti_pkg::flit_t'(app_id));
            send_packet(ti_pkg::MESSAGE_DELIVERY, pay);
            pay[0] = ti_pkg::APP_ALLOCATION_REQUEST;
            send_packet(32'h0000_0055, pay);
            for (int t = 0; t < ntask; t++)
                pay.push_back(recs[p+2+t]);
            send_packet(ti_pkg::MESSAGE_DELIVERY, pay);
            while (pkt_q.size() > 0) @(posedge clk_i);

            for (int t = 0; t < ntask; t++) begin
                tag     = $sformatf("app %h task %0d", app_id, t);
                clen    = code_words(recs[sz+4*t], recs[sz+4*t+1]);
                hdr     = '{default: '0};
                hdr[0]  = recs[p+2+t];
                hdr[1]  = ti_pkg::flit_t'(11 + clen);
                hdr[2]  = ti_pkg::TASK_ALLOCATION;
                hdr[3]  = {16'h0000, app_id, 8'(t)};
                hdr[4]  = MAPPER;
                hdr[9]  = recs[sz+4*t+1];       // Data
                hdr[10] = recs[sz+4*t];         // Text
                hdr[11] = recs[sz+4*t+2];
                hdr[12] = recs[sz+4*t+3];
                for (int i = 0; i < 13; i++)
                    expect_flit($sformatf("%s header %0d", tag, i), hdr[i]);
                for (int i = 0; i < clen; i++)
                    expect_flit($sformatf("%s code %0d", tag, i), {app_id, 8'(t), 16'(i)});
                nflits += 13 + clen;
            end

            while (exp_q.size() > 0) @(posedge clk_i);
            @(posedge clk_i);
            check_count($sformatf("app %h noc flits", app_id), nflits, noc_seen - seen0);
            check_count($sformatf("app %h source words", app_id), nwords, src_taken - taken0);
            check_level($sformatf("app %h completion wait src_credit_o", app_id),
                        1'b0, src_credit_o);

            pay.delete();
            pay.push_back(ti_pkg::APP_MAPPING_COMPLETE);
            pay.push_back(ti_pkg::flit_t'(app_id));
            send_packet(ti_pkg::MESSAGE_DELIVERY, pay);
            while (pkt_q.size() > 0 || !src_credit_o) @(posedge clk_i);   // Back in idle
            p += 2 + 5 * ntask;
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* tb/injector_tests.txt */
// Word 0 is the number of records; a record is app id, task count, one target per task,
// then text size, data size, bss size and entry point (bytes) for each task
3
// App 05, two tasks
05 02
00000102 00000201
00000020 00000010 00000000 00000100
0000001e 00000003 00000008 00000200
// App 2a, three tasks, the last one carries no code
2a 03
00000011 00000203 00000301
00000040 00000000 00000010 00000400
00000008 00000004 00000004 00000500
00000000 00000003 00000000 00000600
// App 77, one task
77 01
00000110
00000030 00000024 00000020 00000700

/* sim.f */
rtl/ti_pkg.sv
rtl/noc_receiver.sv
rtl/task_header_builder.sv
rtl/packet_sender.sv
rtl/injector_ctrl.sv
rtl/task_injector.sv
tb/tb_task_injector.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_task_injector
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= ALL CHECKS PASSED

SRCS := $(shell cat sim.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) sim.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
